// File: decode_pkg.sv
`default_nettype none

package decode_pkg;

   // segment register numbers
   typedef logic [2:0] seg_id_t;

   localparam seg_id_t SEG_ES = 3'd0;
   localparam seg_id_t SEG_CS = 3'd1;
   localparam seg_id_t SEG_SS = 3'd2;
   localparam seg_id_t SEG_DS = 3'd3;
   localparam seg_id_t SEG_FS = 3'd4;
   localparam seg_id_t SEG_GS = 3'd5;

   // immediate size codes, anything else is 32-bit
   localparam logic [1:0] IMM_8  = 2'd0;
   localparam logic [1:0] IMM_16 = 2'd1;

   // operand data size codes
   localparam logic [1:0] DSIZE_BYTE  = 2'd0;
   localparam logic [1:0] DSIZE_WORD  = 2'd1;
   localparam logic [1:0] DSIZE_DWORD = 2'd2;
   localparam logic [1:0] DSIZE_QWORD = 2'd3;

   // opcodes known to the control store
   localparam logic [15:0] OP_ADD_RM    = 16'h0001;
   localparam logic [15:0] OP_GRP1_IMM  = 16'h0081;
   localparam logic [15:0] OP_MOV_R_RM  = 16'h008B;
   localparam logic [15:0] OP_MOV_RM_R  = 16'h0089;
   localparam logic [15:0] OP_MOVQ_ST   = 16'h0F7F;
   localparam logic [15:0] OP_CMPXCHG8  = 16'h0FB0;
   localparam logic [15:0] OP_CMPXCHG32 = 16'h0FB1;
   localparam logic [15:0] OP_JMP_FAR   = 16'h00EA;

   // item handed over by stage one
   typedef struct packed {
      logic [127:0] ir;
      logic [31:0]  eip;
      logic [15:0]  cs;
      logic [3:0]   instr_len;
      logic [15:0]  opcode;
      logic         opcode_size;
      logic         segment_override;
      logic         operand_override;
      logic         modrm_present;
      logic         sib_present;
      logic         disp_present;
      logic         imm_present;
      logic         disp_size;
      logic [1:0]   imm_size;
      logic [2:0]   disp_sel;
      logic [3:0]   imm_sel;
      logic [2:0]   off_sel;
      logic [1:0]   offset_size;
      seg_id_t      seg_id;
      logic [7:0]   modrm;
      logic [7:0]   sib;
   } d1_bundle_t;

   // control word, a set mux bit selects the table value
   typedef struct packed {
      logic [2:0] alu_op;
      logic       mux_alu;
      logic       mem_rd;
      logic       mux_mem_rd;
      logic       mem_wr;
      logic       mux_mem_wr;
      logic       ld_gpr;
      logic       mux_ld_gpr;
      logic [2:0] sr1_id;
      logic       mux_sr1;
      logic [2:0] sr2_id;
      logic       mux_sr2;
      logic       mux_seg1;
      logic       mux_seg2;
      logic       seg1_needed;
      logic       mux_seg1_needed;
      logic       sr1_needed;
      logic       mm1_needed;
      logic       ld_mm;
      logic [1:0] data_size;
      logic [4:0] spare;
   } ctrl_word_t;

   typedef struct packed {
      logic [15:0] opcode;
      ctrl_word_t  ctrl;
   } cs_entry_t;

   // everything forced from the table, values zero
   localparam ctrl_word_t CS_DEFAULT = '{
      mux_alu: 1'b1, mux_mem_rd: 1'b1, mux_mem_wr: 1'b1, mux_ld_gpr: 1'b1,
      mux_sr1: 1'b1, mux_sr2: 1'b1, mux_seg1: 1'b1, mux_seg2: 1'b1,
      mux_seg1_needed: 1'b1, data_size: DSIZE_DWORD, default: '0};

   localparam ctrl_word_t CW_ADD = '{
      mux_alu: 1'b1, sr1_needed: 1'b1, data_size: DSIZE_DWORD, default: '0};
   // alu op comes from modrm reg, no second register source
   localparam ctrl_word_t CW_GRP1 = '{
      mux_sr2: 1'b1, sr1_needed: 1'b1, data_size: DSIZE_DWORD, default: '0};
   localparam ctrl_word_t CW_MOV_R_RM = '{
      mux_alu: 1'b1, mux_mem_wr: 1'b1, ld_gpr: 1'b1, mux_ld_gpr: 1'b1,
      data_size: DSIZE_DWORD, default: '0};
   localparam ctrl_word_t CW_MOV_RM_R = '{
      mux_alu: 1'b1, mux_mem_rd: 1'b1, sr1_needed: 1'b1,
      data_size: DSIZE_DWORD, default: '0};
   localparam ctrl_word_t CW_MOVQ_ST = '{
      mux_alu: 1'b1, mux_mem_rd: 1'b1, mux_ld_gpr: 1'b1, mm1_needed: 1'b1,
      data_size: DSIZE_QWORD, default: '0};
   localparam ctrl_word_t CW_CMPXCHG8 = '{
      alu_op: 3'b001, mux_alu: 1'b1, sr1_needed: 1'b1, data_size: DSIZE_BYTE,
      default: '0};
   localparam ctrl_word_t CW_CMPXCHG32 = '{
      alu_op: 3'b001, mux_alu: 1'b1, sr1_needed: 1'b1, data_size: DSIZE_DWORD,
      default: '0};

   localparam int CS_ENTRIES = 8;

   localparam cs_entry_t CS_TABLE [0:CS_ENTRIES-1] = '{
      '{OP_ADD_RM,    CW_ADD},
      '{OP_GRP1_IMM,  CW_GRP1},
      '{OP_MOV_R_RM,  CW_MOV_R_RM},
      '{OP_MOV_RM_R,  CW_MOV_RM_R},
      '{OP_MOVQ_ST,   CW_MOVQ_ST},
      '{OP_CMPXCHG8,  CW_CMPXCHG8},
      '{OP_CMPXCHG32, CW_CMPXCHG32},
      '{OP_JMP_FAR,   CS_DEFAULT}
   };

   // item passed on to address generation
   typedef struct packed {
      logic [31:0] eip_next;
      logic [15:0] cs;
      ctrl_word_t  ctrl;
      logic [47:0] offset;
      logic [31:0] imm32;
      logic [31:0] disp32;
      logic [1:0]  data_size;
      logic        sr1_needed;
      logic        seg1_needed;
      logic        mm1_needed;
      logic        mem_rd;
      logic        mem_wr;
      logic [2:0]  alu_op;
      logic        ld_gpr;
      logic        ld_mm;
      logic [2:0]  sr1;
      logic [2:0]  sr2;
      logic [2:0]  sr3;
      logic [2:0]  sr4;
      seg_id_t     seg1;
      seg_id_t     seg2;
      logic        sib_en;
      logic        disp_en;
      logic        base_reg_en;
      logic        cs_seg;
      logic        cmpxchg;
      logic [1:0]  sib_scale;
   } d2_bundle_t;

endpackage

`default_nettype wire

// File: pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     valid,
   input  payload_t d,
   output logic     q_valid,
   output payload_t q
);

   // valid follows the strobe one cycle later
   always_ff @(posedge clk) begin
      if (reset) begin
         q_valid <= 1'b0;
      end else begin
         q_valid <= valid;
      end
   end

   // payload holds while idle
   always_ff @(posedge clk) begin
      if (valid) begin
         q <= d;
      end
   end

endmodule

`default_nettype wire

// File: field_extract.sv
`timescale 1ns/1ps
`default_nettype none

module field_extract (
   input  decode_pkg::d1_bundle_t item,
   output logic [31:0]            disp32,
   output logic [31:0]            imm32,
   output logic [47:0]            offset
);

   import decode_pkg::*;

   logic [127:0] disp_win;
   logic [127:0] imm_win;
   logic [127:0] off_win;
   logic         far_16;

   // bring the selected byte down to bit 0, bytes are little-endian
   assign disp_win = item.ir >> {item.disp_sel, 3'b000};
   assign imm_win  = item.ir >> {item.imm_sel, 3'b000};
   assign off_win  = item.ir >> {item.off_sel, 3'b000};

   // disp8 is always sign-extended
   always_comb begin
      if (item.disp_size) begin
         disp32 = disp_win[31:0];
      end else begin
         disp32 = {{24{disp_win[7]}}, disp_win[7:0]};
      end
   end

   always_comb begin
      case (item.imm_size)
         IMM_8: begin
            // group 1 ib is the sign-extended form
            if (item.opcode == OP_GRP1_IMM) begin
               imm32 = {{24{imm_win[7]}}, imm_win[7:0]};
            end else begin
               imm32 = {24'h0, imm_win[7:0]};
            end
         end
         IMM_16: begin
            imm32 = {16'h0, imm_win[15:0]};
         end
         default: begin
            imm32 = imm_win[31:0];
         end
      endcase
   end

   // ptr16:16 form of the far jump
   assign far_16 = item.operand_override && (item.opcode == OP_JMP_FAR);

   // selector sits in [47:32], offset in the low bits
   always_comb begin
      if (far_16) begin
         offset = {off_win[31:16], 16'h0, off_win[15:0]};
      end else begin
         offset = off_win[47:0];
      end
   end

endmodule

`default_nettype wire

// File: control_store.sv
`timescale 1ns/1ps
`default_nettype none

module control_store (
   input  logic [15:0]            opcode,
   input  logic                   opcode_size,
   output decode_pkg::ctrl_word_t ctrl
);

   import decode_pkg::*;

   logic [15:0] key;

   // one-byte opcodes compare with a zero upper byte
   assign key = opcode_size ? opcode : {8'h00, opcode[7:0]};

   // small lookup table in place of the full microcode rom
   always_comb begin
      ctrl = CS_DEFAULT;
      for (int i = 0; i < CS_ENTRIES; i++) begin
         if (CS_TABLE[i].opcode == key) begin
            ctrl = CS_TABLE[i].ctrl;
         end
      end
   end

endmodule

`default_nettype wire

// File: decode_merge.sv
`timescale 1ns/1ps
`default_nettype none

module decode_merge (
   input  decode_pkg::d1_bundle_t item,
   input  decode_pkg::ctrl_word_t ctrl,
   input  logic [31:0]            disp32,
   input  logic [31:0]            imm32,
   input  logic [47:0]            offset,
   output decode_pkg::d2_bundle_t result
);

   import decode_pkg::*;

   logic [1:0] mod_f;
   logic [2:0] reg_f;
   logic [2:0] rm_f;
   logic       mod_reg;
   logic       mod_mem;
   logic       op_0f7f;
   logic [2:0] base_id;
   logic       stack_base;
   seg_id_t    seg_calc;

   assign mod_f = item.modrm[7:6];
   assign reg_f = item.modrm[5:3];
   assign rm_f  = item.modrm[2:0];

   assign mod_reg = (mod_f == 2'b11);
   assign mod_mem = ~mod_reg;

   // movq mm/m64,mm
   assign op_0f7f = (item.opcode == OP_MOVQ_ST);

   // base register comes from sib when present
   assign base_id = item.sib_present ? item.sib[2:0] : rm_f;

   // esp or ebp base defaults to the stack segment
   assign stack_base = (item.sib_present && (item.sib[2:0] == 3'b100)) ||
                       (item.modrm_present && (mod_f == 2'b01 || mod_f == 2'b10) &&
                        (rm_f == 3'b101));

   always_comb begin
      if (item.segment_override) begin
         seg_calc = item.seg_id;
      end else if (stack_base) begin
         seg_calc = SEG_SS;
      end else begin
         seg_calc = SEG_DS;
      end
   end

   always_comb begin
      result.eip_next = item.eip + {28'h0, item.instr_len};
      result.cs       = item.cs;
      result.ctrl     = ctrl;
      result.offset   = offset;
      result.imm32    = imm32;
      result.disp32   = disp32;

      // operand size prefix forces 16-bit
      result.data_size = item.operand_override ? DSIZE_WORD : ctrl.data_size;

      // table or modrm selection, one mux bit each
      result.seg1_needed = ctrl.mux_seg1_needed ? ctrl.seg1_needed : mod_mem;
      result.mem_rd      = ctrl.mux_mem_rd ? ctrl.mem_rd : mod_mem;
      result.mem_wr      = ctrl.mux_mem_wr ? ctrl.mem_wr : mod_mem;
      result.alu_op      = ctrl.mux_alu ? ctrl.alu_op : reg_f;
      result.ld_gpr      = ctrl.mux_ld_gpr ? ctrl.ld_gpr : mod_reg;
      result.sr1         = ctrl.mux_sr1 ? ctrl.sr1_id : base_id;
      result.sr2         = ctrl.mux_sr2 ? ctrl.sr2_id : reg_f;
      result.seg1        = ctrl.mux_seg1 ? SEG_ES : seg_calc;
      result.seg2        = ctrl.mux_seg2 ? reg_f : SEG_SS;

      // mmx rules, 0f7f store writes the mm register in reg form
      result.sr1_needed = ctrl.sr1_needed | (ctrl.mm1_needed & mod_mem);
      result.mm1_needed = ctrl.mm1_needed & mod_reg & ~op_0f7f;
      result.ld_mm      = ctrl.ld_mm | (mod_reg & op_0f7f);

      result.sr3       = reg_f;
      result.sr4       = item.sib[5:3];
      result.sib_scale = item.sib[7:6];
      result.sib_en    = item.sib_present;
      result.disp_en   = item.disp_present;

      // disp32 only, no base register
      result.base_reg_en = (mod_f == 2'b00) && (rm_f == 3'b101);
      result.cs_seg      = (item.seg_id == SEG_CS);
      result.cmpxchg     = ({item.opcode[15:1], 1'b0} == OP_CMPXCHG8);
   end

endmodule

`default_nettype wire

// File: decode_stage2.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage2 (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   in_valid,
   input  decode_pkg::d1_bundle_t in_item,
   output logic                   out_valid,
   output decode_pkg::d2_bundle_t out_item
);

   import decode_pkg::*;

   d1_bundle_t  cap_item;
   logic        cap_valid;
   ctrl_word_t  ctrl;
   logic [31:0] disp32;
   logic [31:0] imm32;
   logic [47:0] offset;
   d2_bundle_t  merged_item;

   // capture from stage one
   pipe_reg #(.payload_t(d1_bundle_t)) u_capture (
      .clk     (clk),
      .reset   (reset),
      .valid   (in_valid),
      .d       (in_item),
      .q_valid (cap_valid),
      .q       (cap_item)
   );

   field_extract u_fields (
      .item   (cap_item),
      .disp32 (disp32),
      .imm32  (imm32),
      .offset (offset)
   );

   control_store u_cstore (
      .opcode      (cap_item.opcode),
      .opcode_size (cap_item.opcode_size),
      .ctrl        (ctrl)
   );

   decode_merge u_merge (
      .item   (cap_item),
      .ctrl   (ctrl),
      .disp32 (disp32),
      .imm32  (imm32),
      .offset (offset),
      .result (merged_item)
   );

   // staging toward address generation
   pipe_reg #(.payload_t(d2_bundle_t)) u_stage (
      .clk     (clk),
      .reset   (reset),
      .valid   (cap_valid),
      .d       (merged_item),
      .q_valid (out_valid),
      .q       (out_item)
   );

endmodule

`default_nettype wire

// File: decode_checker.sv
`timescale 1ns/1ps
`default_nettype none

module decode_checker (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   in_valid,
   input  decode_pkg::d1_bundle_t in_item,
   input  logic                   out_valid,
   input  decode_pkg::d2_bundle_t out_item,
   output int                     error_count,
   output int                     pending
);

   import decode_pkg::*;

   d2_bundle_t exp_q[$];
   int         stamp_q[$];
   int         cycle = 0;
   int         errors = 0;

   assign error_count = errors;

   // byte i of the window, zero past the end
   function automatic logic [7:0] ir_byte(input logic [127:0] ir, input int idx);
      if (idx > 15) begin
         return 8'h00;
      end
      return ir[idx*8 +: 8];
   endfunction

   // reference copy of the control store
   function automatic ctrl_word_t table_word(input logic [15:0] key);
      ctrl_word_t cw;
      cw = '0;
      cw.data_size = 2'd2;
      case (key)
         OP_ADD_RM: begin
            cw.mux_alu    = 1'b1;
            cw.sr1_needed = 1'b1;
         end
         OP_GRP1_IMM: begin
            cw.mux_sr2    = 1'b1;
            cw.sr1_needed = 1'b1;
         end
         OP_MOV_R_RM: begin
            cw.mux_alu    = 1'b1;
            cw.mux_mem_wr = 1'b1;
            cw.ld_gpr     = 1'b1;
            cw.mux_ld_gpr = 1'b1;
         end
         OP_MOV_RM_R: begin
            cw.mux_alu    = 1'b1;
            cw.mux_mem_rd = 1'b1;
            cw.sr1_needed = 1'b1;
         end
         OP_MOVQ_ST: begin
            cw.mux_alu    = 1'b1;
            cw.mux_mem_rd = 1'b1;
            cw.mux_ld_gpr = 1'b1;
            cw.mm1_needed = 1'b1;
            cw.data_size  = 2'd3;
         end
         OP_CMPXCHG8, OP_CMPXCHG32: begin
            cw.alu_op     = 3'b001;
            cw.mux_alu    = 1'b1;
            cw.sr1_needed = 1'b1;
            cw.data_size  = (key == OP_CMPXCHG8) ? 2'd0 : 2'd2;
         end
         // far jump shares the default word
         default: begin
            cw.mux_alu         = 1'b1;
            cw.mux_mem_rd      = 1'b1;
            cw.mux_mem_wr      = 1'b1;
            cw.mux_ld_gpr      = 1'b1;
            cw.mux_sr1         = 1'b1;
            cw.mux_sr2         = 1'b1;
            cw.mux_seg1        = 1'b1;
            cw.mux_seg2        = 1'b1;
            cw.mux_seg1_needed = 1'b1;
         end
      endcase
      return cw;
   endfunction

   function automatic d2_bundle_t expected_item(input d1_bundle_t it);
      d2_bundle_t  e;
      ctrl_word_t  cw;
      logic [1:0]  mod_f;
      logic [2:0]  reg_f;
      logic [2:0]  rm_f;
      logic        in_reg;
      logic        in_mem;
      logic        is_movq;
      int          ds;
      int          is;
      int          os;
      seg_id_t     seg_calc;
      e = '0;
      cw = table_word(it.opcode_size ? it.opcode : {8'h00, it.opcode[7:0]});
      mod_f = it.modrm[7:6];
      reg_f = it.modrm[5:3];
      rm_f = it.modrm[2:0];
      in_reg = (mod_f == 2'b11);
      in_mem = !in_reg;
      is_movq = (it.opcode == OP_MOVQ_ST);
      ds = int'(it.disp_sel);
      is = int'(it.imm_sel);
      os = int'(it.off_sel);

      if (it.disp_size) begin
         e.disp32 = {ir_byte(it.ir, ds + 3), ir_byte(it.ir, ds + 2),
                     ir_byte(it.ir, ds + 1), ir_byte(it.ir, ds)};
      end else begin
         e.disp32 = {{24{it.ir[ds*8 + 7]}}, ir_byte(it.ir, ds)};
      end

      if (it.imm_size == 2'd0) begin
         e.imm32 = {24'h0, ir_byte(it.ir, is)};
         if (it.opcode == OP_GRP1_IMM) begin
            e.imm32[31:8] = {24{e.imm32[7]}};
         end
      end else if (it.imm_size == 2'd1) begin
         e.imm32 = {16'h0, ir_byte(it.ir, is + 1), ir_byte(it.ir, is)};
      end else begin
         e.imm32 = {ir_byte(it.ir, is + 3), ir_byte(it.ir, is + 2),
                    ir_byte(it.ir, is + 1), ir_byte(it.ir, is)};
      end

      // ptr16:16 keeps the selector on top, middle bits clear
      if (it.operand_override && it.opcode == OP_JMP_FAR) begin
         e.offset = {ir_byte(it.ir, os + 3), ir_byte(it.ir, os + 2), 16'h0,
                     ir_byte(it.ir, os + 1), ir_byte(it.ir, os)};
      end else begin
         e.offset = {ir_byte(it.ir, os + 5), ir_byte(it.ir, os + 4),
                     ir_byte(it.ir, os + 3), ir_byte(it.ir, os + 2),
                     ir_byte(it.ir, os + 1), ir_byte(it.ir, os)};
      end

      if (it.segment_override) begin
         seg_calc = it.seg_id;
      end else if ((it.sib_present && it.sib[2:0] == 3'b100) ||
                   (it.modrm_present && (mod_f == 2'b01 || mod_f == 2'b10) &&
                    rm_f == 3'b101)) begin
         seg_calc = SEG_SS;
      end else begin
         seg_calc = SEG_DS;
      end

      e.eip_next    = it.eip + 32'(it.instr_len);
      e.cs          = it.cs;
      e.ctrl        = cw;
      e.data_size   = it.operand_override ? 2'd1 : cw.data_size;
      e.mem_rd      = cw.mux_mem_rd ? cw.mem_rd : in_mem;
      e.mem_wr      = cw.mux_mem_wr ? cw.mem_wr : in_mem;
      e.seg1_needed = cw.mux_seg1_needed ? cw.seg1_needed : in_mem;
      e.ld_gpr      = cw.mux_ld_gpr ? cw.ld_gpr : in_reg;
      e.alu_op      = cw.mux_alu ? cw.alu_op : reg_f;
      e.sr1         = cw.mux_sr1 ? cw.sr1_id : (it.sib_present ? it.sib[2:0] : rm_f);
      e.sr2         = cw.mux_sr2 ? cw.sr2_id : reg_f;
      e.seg1        = cw.mux_seg1 ? SEG_ES : seg_calc;
      e.seg2        = cw.mux_seg2 ? reg_f : SEG_SS;
      e.sr1_needed  = cw.sr1_needed || (cw.mm1_needed && in_mem);
      e.mm1_needed  = cw.mm1_needed && in_reg && !is_movq;
      e.ld_mm       = cw.ld_mm || (in_reg && is_movq);
      e.cmpxchg     = (it.opcode == OP_CMPXCHG8) || (it.opcode == OP_CMPXCHG32);
      e.base_reg_en = (mod_f == 2'b00) && (rm_f == 3'b101);
      e.cs_seg      = (it.seg_id == SEG_CS);
      e.sr3         = reg_f;
      e.sr4         = it.sib[5:3];
      e.sib_scale   = it.sib[7:6];
      e.sib_en      = it.sib_present;
      e.disp_en     = it.disp_present;
      return e;
   endfunction

   task automatic check_field(input string name, input logic [63:0] exp_v,
                              input logic [63:0] act_v);
      if (exp_v !== act_v) begin
         errors++;
         $display("[FAIL] %0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
      end
   endtask

   task automatic compare_item(input d2_bundle_t e, input d2_bundle_t a);
      check_field("eip_next", 64'(e.eip_next), 64'(a.eip_next));
      check_field("cs", 64'(e.cs), 64'(a.cs));
      check_field("ctrl", 64'(e.ctrl), 64'(a.ctrl));
      check_field("offset", 64'(e.offset), 64'(a.offset));
      check_field("imm32", 64'(e.imm32), 64'(a.imm32));
      check_field("disp32", 64'(e.disp32), 64'(a.disp32));
      check_field("data_size", 64'(e.data_size), 64'(a.data_size));
      check_field("sr1_needed", 64'(e.sr1_needed), 64'(a.sr1_needed));
      check_field("seg1_needed", 64'(e.seg1_needed), 64'(a.seg1_needed));
      check_field("mm1_needed", 64'(e.mm1_needed), 64'(a.mm1_needed));
      check_field("mem_rd", 64'(e.mem_rd), 64'(a.mem_rd));
      check_field("mem_wr", 64'(e.mem_wr), 64'(a.mem_wr));
      check_field("alu_op", 64'(e.alu_op), 64'(a.alu_op));
      check_field("ld_gpr", 64'(e.ld_gpr), 64'(a.ld_gpr));
      check_field("ld_mm", 64'(e.ld_mm), 64'(a.ld_mm));
      check_field("sr1", 64'(e.sr1), 64'(a.sr1));
      check_field("sr2", 64'(e.sr2), 64'(a.sr2));
      check_field("sr3", 64'(e.sr3), 64'(a.sr3));
      check_field("sr4", 64'(e.sr4), 64'(a.sr4));
      check_field("seg1", 64'(e.seg1), 64'(a.seg1));
      check_field("seg2", 64'(e.seg2), 64'(a.seg2));
      check_field("sib_en", 64'(e.sib_en), 64'(a.sib_en));
      check_field("disp_en", 64'(e.disp_en), 64'(a.disp_en));
      check_field("base_reg_en", 64'(e.base_reg_en), 64'(a.base_reg_en));
      check_field("cs_seg", 64'(e.cs_seg), 64'(a.cs_seg));
      check_field("cmpxchg", 64'(e.cmpxchg), 64'(a.cmpxchg));
      check_field("sib_scale", 64'(e.sib_scale), 64'(a.sib_scale));
   endtask

   // outputs are read before this edge updates them, result due two edges after the strobe
   always @(posedge clk) begin
      if (reset) begin
         if (cycle > 0 && out_valid !== 1'b0) begin
            errors++;
            $display("error at %0t: out_valid is not low during reset", $time);
         end
         exp_q.delete();
         stamp_q.delete();
      end else begin
         if (out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
               errors++;
               $display("error at %0t: out_valid pulse with no item in flight", $time);
            end else begin
               if (cycle != stamp_q[0] + 2) begin
                  errors++;
                  $display("error at %0t: item sampled in cycle %0d came out in cycle %0d",
                           $time, stamp_q[0], cycle);
               end
               compare_item(exp_q[0], out_item);
               void'(exp_q.pop_front());
               void'(stamp_q.pop_front());
            end
         end else if (exp_q.size() != 0 && cycle > stamp_q[0] + 2) begin
            errors++;
            $display("error at %0t: no output for item sampled in cycle %0d",
                     $time, stamp_q[0]);
            void'(exp_q.pop_front());
            void'(stamp_q.pop_front());
         end
         if (in_valid === 1'b1) begin
            exp_q.push_back(expected_item(in_item));
            stamp_q.push_back(cycle);
         end
      end
      cycle++;
      pending = exp_q.size();
   end

endmodule

`default_nettype wire

// File: tb_decode_stage2.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage2;

   import decode_pkg::*;

   localparam int NUM_CYCLES  = 400;
   localparam int DRAIN_LIMIT = 20;
   // x^32 + x^22 + x^2 + x + 1
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

   logic        clk;
   logic        reset;
   logic        in_valid;
   d1_bundle_t  in_item;
   logic        out_valid;
   d2_bundle_t  out_item;
   int          check_errors;
   int          pending;
   int          timeouts;
   int          waited;
   logic [31:0] lfsr_state;

   decode_stage2 dut (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (in_valid),
      .in_item   (in_item),
      .out_valid (out_valid),
      .out_item  (out_item)
   );

   decode_checker u_check (
      .clk         (clk),
      .reset       (reset),
      .in_valid    (in_valid),
      .in_item     (in_item),
      .out_valid   (out_valid),
      .out_item    (out_item),
      .error_count (check_errors),
      .pending     (pending)
   );

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
   endfunction

   // one lfsr step per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      int          k;
      v = '0;
      for (k = 0; k < n; k++) begin
         v = {v[30:0], lfsr_state[0]};
         lfsr_state = lfsr_step(lfsr_state);
      end
      return v;
   endfunction

   function automatic d1_bundle_t build_item();
      d1_bundle_t  it;
      logic [31:0] pick;
      it = '0;
      it.ir = {take_bits(32), take_bits(32), take_bits(32), take_bits(32)};
      it.eip = take_bits(32);
      // push some items across the 4G boundary
      if (take_bits(2) == 0) begin
         it.eip = 32'hFFFF_FFF0 | take_bits(4);
      end
      it.cs = 16'(take_bits(16));
      it.instr_len = 4'(take_bits(4));
      pick = take_bits(4);
      case (pick[3:0])
         4'd0: it.opcode = OP_ADD_RM;
         4'd1: it.opcode = OP_GRP1_IMM;
         4'd2: it.opcode = OP_MOV_R_RM;
         4'd3: it.opcode = OP_MOV_RM_R;
         4'd4: it.opcode = OP_MOVQ_ST;
         4'd5: it.opcode = OP_CMPXCHG8;
         4'd6: it.opcode = OP_CMPXCHG32;
         4'd7: it.opcode = OP_JMP_FAR;
         default: begin
            it.opcode = 16'(take_bits(16));
            if (take_bits(1) == 1) begin
               it.opcode[15:8] = 8'h00;
            end
         end
      endcase
      it.opcode_size = (it.opcode[15:8] != 8'h00);
      // stale upper byte on a one-byte opcode
      if (!it.opcode_size && take_bits(2) == 0) begin
         it.opcode[15:8] = 8'(take_bits(8)) | 8'h80;
      end
      it.segment_override = take_bits(1) == 1;
      it.operand_override = take_bits(1) == 1;
      it.modrm_present = take_bits(1) == 1;
      it.sib_present = take_bits(1) == 1;
      it.disp_present = take_bits(1) == 1;
      it.imm_present = take_bits(1) == 1;
      it.disp_size = take_bits(1) == 1;
      it.imm_size = 2'(take_bits(2));
      // selects stay inside the 16-byte window
      it.disp_sel = 3'(take_bits(3));
      it.imm_sel = 4'(take_bits(4) % 13);
      it.off_sel = 3'(take_bits(3));
      it.offset_size = 2'(take_bits(2));
      it.seg_id = 3'(take_bits(3) % 6);
      it.modrm = 8'(take_bits(8));
      it.sib = 8'(take_bits(8));
      return it;
   endfunction

   initial begin
      clk = 1'b0;
      forever begin
         #20 clk = ~clk;
      end
   end

   initial begin
      reset = 1'b1;
      in_valid = 1'b0;
      in_item = '0;
      timeouts = 0;
      lfsr_state = 32'd31;
      repeat (10) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // first items back to back before the random gaps
      for (int i = 0; i < NUM_CYCLES; i++) begin
         @(negedge clk);
         in_valid = (i < 8) || (take_bits(2) != 0);
         if (in_valid) begin
            in_item = build_item();
         end
      end
      @(negedge clk);
      in_valid = 1'b0;

      waited = 0;
      while (pending != 0 && waited < DRAIN_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (pending != 0) begin
         timeouts++;
         $display("timeout: %0d items still in flight after %0d cycles", pending, waited);
      end

      $display("errors: %0d compare, %0d timeout", check_errors, timeouts);
      if (check_errors == 0 && timeouts == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: files.f
decode_pkg.sv
pipe_reg.sv
field_extract.sv
control_store.sv
decode_merge.sv
decode_stage2.sv
decode_checker.sv
tb_decode_stage2.sv

// File: run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
SIM_BIN=sim_decode_stage2

verilator --binary --timing --timescale 1ns/1ps \
   -f files.f \
   --top-module tb_decode_stage2 \
   --Mdir "$BUILD_DIR" \
   -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^PASS: all tests$" "$LOG_FILE"; then
   exit 0
fi
echo "pass message not found in $LOG_FILE"
exit 1
